// File: Bender.yml
package:
  name: dmmu

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/dmmu_pkg.sv
      - src/dmmu_if.sv
      - src/tlb_spram.sv
      - src/dmmu.sv
      - src/lsu_translate_stage.sv
      - src/dmmu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/dmmu_checker.sv
      - verification/dmmu_tb.sv

// File: src/dmmu.sv
// Direct-mapped data TLB with SPR access and hit, miss and permission checks
`timescale 1ns/1ns

`include "dmmu_config.svh"

module dmmu (
   input  logic clk,
   input  logic rst,
   spr_bus_if.slave  spr,
   tlb_lookup_if.tlb lkp
);

   import dmmu_pkg::*;

   logic                       mr_cs;        // Match window selected
   logic                       tr_cs;        // Translate window selected
   logic                       mr_sel_r;     // Window of the access being acked
   logic                       ack_r;

   logic [`DMMU_SET_WIDTH-1:0] lookup_set;
   logic [`DMMU_SET_WIDTH-1:0] match_ram_addr;
   logic [`DMMU_SET_WIDTH-1:0] trans_ram_addr;
   logic                       match_ram_we;
   logic                       trans_ram_we;

   tlb_word_u                  wr_word;      // SPR write data
   tlb_word_u                  match_word;   // Match RAM output
   tlb_word_u                  trans_word;   // Translate RAM output

   logic                       user_fault;
   logic                       super_fault;

   // SPR window decode
   assign mr_cs = spr.stb &
                  (spr.addr >= `SPR_DTLB_MR_BASE) &
                  (spr.addr <  `SPR_DTLB_TR_BASE);
   assign tr_cs = spr.stb &
                  (spr.addr >= `SPR_DTLB_TR_BASE) &
                  (spr.addr <  `SPR_DTLB_END);

   // Index bits just above the page offset
   assign lookup_set = lkp.lookup_addr[`DMMU_PAGE_BITS +: `DMMU_SET_WIDTH];

   // SPR access takes the RAM port over the lookup
   assign match_ram_addr = mr_cs ? spr.addr[`DMMU_SET_WIDTH-1:0] : lookup_set;
   assign trans_ram_addr = tr_cs ? spr.addr[`DMMU_SET_WIDTH-1:0] : lookup_set;

   assign match_ram_we = mr_cs & spr.we;
   assign trans_ram_we = tr_cs & spr.we;

   assign wr_word.raw = spr.wdat;  // Stored whole, reserved bits included

   // Ack one cycle after strobe, never twice in a row
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_r    <= 1'b0;
         mr_sel_r <= 1'b0;
      end else begin
         ack_r    <= (mr_cs | tr_cs) & ~ack_r;
         mr_sel_r <= mr_cs;
      end
   end

   assign spr.ack  = ack_r;
   assign spr.rdat = mr_sel_r ? match_word.raw : trans_word.raw;  // RAM data lands with ack

   // Match words
   tlb_spram #(
      .ADDR_WIDTH (`DMMU_SET_WIDTH),
      .DATA_WIDTH (`DMMU_DATA_WIDTH)
   ) match_ram (
      .clk    (clk),
      .addr_i (match_ram_addr),
      .we_i   (match_ram_we),
      .din_i  (wr_word.match),
      .dout_o (match_word)
   );

   // Translate words
   tlb_spram #(
      .ADDR_WIDTH (`DMMU_SET_WIDTH),
      .DATA_WIDTH (`DMMU_DATA_WIDTH)
   ) trans_ram (
      .clk    (clk),
      .addr_i (trans_ram_addr),
      .we_i   (trans_ram_we),
      .din_i  (wr_word.trans),
      .dout_o (trans_word)
   );

   // Compare cycle, RAM words belong to match_addr
   assign lkp.miss = ~match_word.match.valid |
                     (match_word.match.vpn !=
                      lkp.match_addr[`DMMU_DATA_WIDTH-1:`DMMU_PAGE_BITS]);

   // Permission checks per privilege level
   assign super_fault = (lkp.store & ~trans_word.trans.swe) |
                        (lkp.load  & ~trans_word.trans.sre);
   assign user_fault  = (lkp.store & ~trans_word.trans.uwe) |
                        (lkp.load  & ~trans_word.trans.ure);
   assign lkp.pagefault = lkp.supervisor ? super_fault : user_fault;

   // Page number from TLB, offset from the held address
   assign lkp.phys_addr = {trans_word.trans.ppn,
                           lkp.match_addr[`DMMU_PAGE_BITS-1:0]};
   assign lkp.ci        = trans_word.trans.ci;

endmodule

// File: src/dmmu_config.svh
// Width, page and SPR window constants for the data MMU; include wherever they are needed
`ifndef DMMU_CONFIG_SVH
`define DMMU_CONFIG_SVH

// Operand and SPR data width
`define DMMU_DATA_WIDTH 32

// Set index width, RAM depth is 2**this
`define DMMU_SET_WIDTH 6

// Page offset width for 8 KiB pages
`define DMMU_PAGE_BITS 13

// SPR address width of the bus
`define DMMU_SPR_ADDR_WIDTH 16

// Way 0 match registers
`define SPR_DTLB_MR_BASE 16'h0A00
// Way 0 translate registers
`define SPR_DTLB_TR_BASE 16'h0A80
// First address past the translate window
`define SPR_DTLB_END 16'h0B00

`endif

// File: src/dmmu_if.sv
// SPR bus and TLB lookup interfaces used between the data MMU blocks
`timescale 1ns/1ns

`include "dmmu_config.svh"

// SPR access, stb held until ack
interface spr_bus_if;
   logic [`DMMU_SPR_ADDR_WIDTH-1:0] addr;
   logic                            we;
   logic                            stb;
   logic [`DMMU_DATA_WIDTH-1:0]     wdat;
   logic [`DMMU_DATA_WIDTH-1:0]     rdat;  // Valid while ack is high
   logic                            ack;   // One cycle pulse

   modport master (output addr, output we, output stb, output wdat,
                   input rdat, input ack);
   modport slave (input addr, input we, input stb, input wdat,
                  output rdat, output ack);
endinterface

// Lookup between the request stage and the TLB
interface tlb_lookup_if;
   logic [`DMMU_DATA_WIDTH-1:0] lookup_addr;  // Request cycle, indexes the RAMs
   logic [`DMMU_DATA_WIDTH-1:0] match_addr;   // Compare cycle, held address
   logic                        supervisor;
   logic                        load;
   logic                        store;
   logic [`DMMU_DATA_WIDTH-1:0] phys_addr;
   logic                        ci;
   logic                        miss;
   logic                        pagefault;

   modport requester (output lookup_addr, output match_addr,
                      output supervisor, output load, output store,
                      input phys_addr, input ci, input miss, input pagefault);
   modport tlb (input lookup_addr, input match_addr,
                input supervisor, input load, input store,
                output phys_addr, output ci, output miss, output pagefault);
endinterface

// File: src/dmmu_pkg.sv
// TLB entry word types for the data MMU; import into modules that decode entries
package dmmu_pkg;

`include "dmmu_config.svh"

   // Match word, one per set
   typedef struct packed {
      logic [`DMMU_DATA_WIDTH-`DMMU_PAGE_BITS-1:0] vpn;   // Virtual page number
      logic [`DMMU_PAGE_BITS-2:0]                  rsvd;  // Unused bits
      logic                                        valid; // Entry valid
   } tlb_match_t;

   // Translate word, one per set
   typedef struct packed {
      logic [`DMMU_DATA_WIDTH-`DMMU_PAGE_BITS-1:0] ppn;     // Physical page number
      logic [`DMMU_PAGE_BITS-11:0]                 rsvd_hi; // Bits 12 to 10
      logic                                        swe;     // Supervisor write enable
      logic                                        sre;     // Supervisor read enable
      logic                                        uwe;     // User write enable
      logic                                        ure;     // User read enable
      logic [3:0]                                  rsvd_mid;
      logic                                        ci;      // Cache inhibit
      logic                                        rsvd_lo;
   } tlb_trans_t;

   // Same 32 bits seen raw or as either entry kind
   typedef union packed {
      logic [`DMMU_DATA_WIDTH-1:0] raw;
      tlb_match_t                  match;
      tlb_trans_t                  trans;
   } tlb_word_u;

endpackage

// File: src/dmmu_top.sv
// Data address translation top level; plain SPR and request ports around the MMU and stage
`timescale 1ns/1ns

`include "dmmu_config.svh"

module dmmu_top (
   input  logic                           clk,
   input  logic                           rst,
   // SPR bus
   input  logic [`DMMU_SPR_ADDR_WIDTH-1:0] spr_addr_i,
   input  logic                           spr_we_i,
   input  logic                           spr_stb_i,
   input  logic [`DMMU_DATA_WIDTH-1:0]    spr_dat_i,
   output logic [`DMMU_DATA_WIDTH-1:0]    spr_dat_o,
   output logic                           spr_ack_o,
   // Load/store request
   input  logic                           req_i,
   input  logic [`DMMU_DATA_WIDTH-1:0]    vaddr_i,
   input  logic                           load_i,
   input  logic                           store_i,
   input  logic                           supervisor_i,
   input  logic                           dmmu_en_i,
   // Translation response
   output logic                           rsp_valid_o,
   output logic [`DMMU_DATA_WIDTH-1:0]    paddr_o,
   output logic                           ci_o,
   output logic                           miss_o,
   output logic                           pagefault_o
);

   spr_bus_if    spr ();
   tlb_lookup_if lkp ();

   // Top acts as SPR master
   assign spr.addr  = spr_addr_i;
   assign spr.we    = spr_we_i;
   assign spr.stb   = spr_stb_i;
   assign spr.wdat  = spr_dat_i;
   assign spr_dat_o = spr.rdat;
   assign spr_ack_o = spr.ack;

   dmmu u_dmmu (
      .clk (clk),
      .rst (rst),
      .spr (spr.slave),
      .lkp (lkp.tlb)
   );

   lsu_translate_stage u_stage (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req_i),
      .vaddr_i      (vaddr_i),
      .load_i       (load_i),
      .store_i      (store_i),
      .supervisor_i (supervisor_i),
      .dmmu_en_i    (dmmu_en_i),
      .lkp          (lkp.requester),
      .rsp_valid_o  (rsp_valid_o),
      .paddr_o      (paddr_o),
      .ci_o         (ci_o),
      .miss_o       (miss_o),
      .pagefault_o  (pagefault_o)
   );

endmodule

// File: src/lsu_translate_stage.sv
// Load/store request and compare pipeline feeding the TLB, registers the response
`timescale 1ns/1ns

`include "dmmu_config.svh"

module lsu_translate_stage (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        req_i,
   input  logic [`DMMU_DATA_WIDTH-1:0] vaddr_i,
   input  logic                        load_i,
   input  logic                        store_i,
   input  logic                        supervisor_i,
   input  logic                        dmmu_en_i,
   tlb_lookup_if.requester             lkp,
   output logic                        rsp_valid_o,
   output logic [`DMMU_DATA_WIDTH-1:0] paddr_o,
   output logic                        ci_o,
   output logic                        miss_o,
   output logic                        pagefault_o
);

   // Compare register
   logic                        req_q;
   logic [`DMMU_DATA_WIDTH-1:0] vaddr_q;
   logic                        load_q;
   logic                        store_q;
   logic                        supervisor_q;
   logic                        en_q;         // Translation enable for this request

   // Request cycle drives the RAM index directly
   assign lkp.lookup_addr = vaddr_i;

   // Held fields go to the TLB in the compare cycle
   assign lkp.match_addr = vaddr_q;
   assign lkp.load       = load_q;
   assign lkp.store      = store_q;
   assign lkp.supervisor = supervisor_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         req_q <= 1'b0;
      end else begin
         req_q <= req_i;
      end
   end

   always_ff @(posedge clk) begin
      vaddr_q      <= vaddr_i;
      load_q       <= load_i;
      store_q      <= store_i;
      supervisor_q <= supervisor_i;
      en_q         <= dmmu_en_i;
   end

   // Response valid trails the request by two edges
   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= req_q;
      end
   end

   // Response payload
   always_ff @(posedge clk) begin
      if (en_q) begin
         paddr_o     <= lkp.phys_addr;
         ci_o        <= lkp.ci;
         miss_o      <= lkp.miss;
         pagefault_o <= lkp.pagefault & ~lkp.miss;  // Miss has priority
      end else begin
         paddr_o     <= vaddr_q;  // Bypass, physical equals virtual
         ci_o        <= 1'b0;
         miss_o      <= 1'b0;
         pagefault_o <= 1'b0;
      end
   end

endmodule

// File: src/tlb_spram.sv
// Single-port RAM with registered read address, holds one TLB array
`timescale 1ns/1ns

module tlb_spram #(
   parameter int ADDR_WIDTH = 6,
   parameter int DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic [ADDR_WIDTH-1:0] addr_i,
   input  logic                  we_i,
   input  logic [DATA_WIDTH-1:0] din_i,
   output logic [DATA_WIDTH-1:0] dout_o
);

   logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];  // No reset, contents undefined
   logic [ADDR_WIDTH-1:0] addr_r;

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[addr_i] <= din_i;
      end
      addr_r <= addr_i;  // Read address latched every cycle
   end

   // Read after write, same address gives new data
   assign dout_o = mem[addr_r];

endmodule

// File: tb.f
+incdir+src
src/dmmu_pkg.sv
src/dmmu_if.sv
src/tlb_spram.sv
src/dmmu.sv
src/lsu_translate_stage.sv
src/dmmu_top.sv
verification/dmmu_checker.sv
verification/dmmu_tb.sv

// File: verification/dmmu_checker.sv
// Concurrent assertions on SPR ack and response timing, bound into dmmu_top
`timescale 1ns/1ns

module dmmu_checker (
   input logic clk,
   input logic rst,
   input logic spr_stb_i,
   input logic spr_ack_i,
   input logic req_i,
   input logic rsp_valid_i,
   input logic miss_i,
   input logic pagefault_i
);

   // Ack is a single pulse even with stb still held
   ack_single: assert property (@(posedge clk) disable iff (rst)
      spr_stb_i && spr_ack_i |=> !spr_ack_i)
      else $error("SPR ack high for two cycles in a row");

   // Ack only answers a strobe
   ack_after_stb: assert property (@(posedge clk) disable iff (rst)
      spr_ack_i |-> $past(spr_stb_i))
      else $error("SPR ack without a strobe in the previous cycle");

   // Fixed two-cycle latency
   rsp_latency: assert property (@(posedge clk) disable iff (rst)
      rsp_valid_i == $past(req_i, 2))
      else $error("response valid does not trail the request by two cycles");

   // Miss masks the page fault
   miss_no_fault: assert property (@(posedge clk) disable iff (rst)
      rsp_valid_i |-> !(miss_i && pagefault_i))
      else $error("miss and page fault reported together");

endmodule

bind dmmu_top dmmu_checker u_checker (
   .clk         (clk),
   .rst         (rst),
   .spr_stb_i   (spr_stb_i),
   .spr_ack_i   (spr_ack_o),
   .req_i       (req_i),
   .rsp_valid_i (rsp_valid_o),
   .miss_i      (miss_o),
   .pagefault_i (pagefault_o)
);

// File: verification/dmmu_tb.sv
// Self-checking testbench for dmmu_top; runs a table of SPR accesses and lookups against a model
`timescale 1ns/1ns

`include "dmmu_config.svh"

module dmmu_tb;

   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 8;
   localparam int OP_WR      = 0;  // SPR write
   localparam int OP_RD      = 1;  // SPR read, compared with exp_data
   localparam int OP_LK      = 2;  // Lookup, compared when the response shows up

   typedef struct {
      int          op;
      int          idx;
      logic [31:0] addr;      // SPR address or virtual address
      logic [31:0] data;
      logic        ld;
      logic        st;
      logic        sv;
      logic        en;
      logic [31:0] exp_data;  // Read data or physical address
      logic        exp_ci;
      logic        exp_miss;
      logic        exp_pf;
   } row_t;

   logic                            clk;
   logic                            rst;
   logic [`DMMU_SPR_ADDR_WIDTH-1:0] spr_addr_i;
   logic                            spr_we_i;
   logic                            spr_stb_i;
   logic [`DMMU_DATA_WIDTH-1:0]     spr_dat_i;
   logic [`DMMU_DATA_WIDTH-1:0]     spr_dat_o;
   logic                            spr_ack_o;
   logic                            req_i;
   logic [`DMMU_DATA_WIDTH-1:0]     vaddr_i;
   logic                            load_i;
   logic                            store_i;
   logic                            supervisor_i;
   logic                            dmmu_en_i;
   logic                            rsp_valid_o;
   logic [`DMMU_DATA_WIDTH-1:0]     paddr_o;
   logic                            ci_o;
   logic                            miss_o;
   logic                            pagefault_o;

   row_t        tbl[$];                          // Stimulus and expected values
   row_t        pending_q[$];                    // Lookups waiting for their response
   logic [31:0] mr_model [2**`DMMU_SET_WIDTH];   // Match words as written
   logic [31:0] tr_model [2**`DMMU_SET_WIDTH];   // Translate words as written
   integer      seed = 32'h858b416f;
   int          n_tests = 0;
   int          n_errors = 0;
   logic        table_ready = 1'b0;

   dmmu_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   function automatic logic [31:0] match_word(logic [12:0] tag, logic [5:0] set, logic valid);
      return {tag, set, 12'h000, valid};
   endfunction

   // Perms in order swe, sre, uwe, ure
   function automatic logic [31:0] trans_word(logic [18:0] ppn, logic [3:0] perms, logic ci);
      return {ppn, 3'b000, perms, 4'b0000, ci, 1'b0};
   endfunction

   task automatic add_spr(input int op, input logic [15:0] base, input logic [5:0] set,
                          input logic [31:0] data);
      row_t r;
      r = '{default: '0};
      r.op   = op;
      r.addr = base + set;
      r.data = data;
      if (op == OP_WR && base == `SPR_DTLB_MR_BASE) mr_model[set] = data;
      else if (op == OP_WR) tr_model[set] = data;
      r.exp_data = (base == `SPR_DTLB_MR_BASE) ? mr_model[set] : tr_model[set];
      tbl.push_back(r);
   endtask

   // Write both words of a set and read each back
   task automatic add_entry(input logic [5:0] set, input logic [31:0] mw, input logic [31:0] tw);
      add_spr(OP_WR, `SPR_DTLB_MR_BASE, set, mw);
      add_spr(OP_RD, `SPR_DTLB_MR_BASE, set, 32'h0);
      add_spr(OP_WR, `SPR_DTLB_TR_BASE, set, tw);
      add_spr(OP_RD, `SPR_DTLB_TR_BASE, set, 32'h0);
   endtask

   // Expected response straight from the entry format and permission rules
   task automatic add_lookup(input logic [31:0] va, input logic ld, st, sv, en);
      row_t        r;
      logic [31:0] mw;
      logic [31:0] tw;
      logic        wr_ok;
      logic        rd_ok;
      mw = mr_model[va[`DMMU_PAGE_BITS +: `DMMU_SET_WIDTH]];
      tw = tr_model[va[`DMMU_PAGE_BITS +: `DMMU_SET_WIDTH]];
      r = '{default: '0};
      r.op = OP_LK;
      r.addr = va;
      r.ld = ld;
      r.st = st;
      r.sv = sv;
      r.en = en;
      r.exp_data = va;  // Bypass value
      if (en) begin
         wr_ok = sv ? tw[9] : tw[7];  // swe or uwe
         rd_ok = sv ? tw[8] : tw[6];  // sre or ure
         r.exp_miss = !mw[0] || (mw[31:13] != va[31:13]);
         r.exp_pf   = !r.exp_miss && ((st && !wr_ok) || (ld && !rd_ok));
         r.exp_data = {tw[31:13], va[12:0]};
         r.exp_ci   = tw[1];
      end
      tbl.push_back(r);
   endtask

   task automatic build_table();
      logic [31:0] rnd;
      logic [31:0] va_rnd [6];
      add_entry(6'd1, match_word(13'h0123, 6'd1, 1'b1), trans_word(19'h5A5A1, 4'b1111, 1'b1));
      add_entry(6'd2, match_word(13'h0456, 6'd2, 1'b0), trans_word(19'h12345, 4'b0000, 1'b0));
      add_entry(6'd3, match_word(13'h1ABC, 6'd3, 1'b1), trans_word(19'h7FFF3, 4'b0110, 1'b0));
      add_lookup({13'h0123, 6'd1, 13'h0ABC}, 1'b1, 1'b0, 1'b0, 1'b1);  // Hit, user load
      add_lookup({13'h0123, 6'd1, 13'h1FFF}, 1'b0, 1'b1, 1'b1, 1'b1);  // Hit, supervisor store
      add_lookup({13'h0456, 6'd2, 13'h0010}, 1'b1, 1'b0, 1'b0, 1'b1);  // Valid low, no perms
      add_lookup({13'h1ABD, 6'd3, 13'h0010}, 1'b1, 1'b0, 1'b0, 1'b1);  // Other VPN, same set
      add_lookup({13'h1ABC, 6'd3, 13'h0004}, 1'b1, 1'b0, 1'b0, 1'b1);  // ure clear
      add_lookup({13'h1ABC, 6'd3, 13'h0008}, 1'b0, 1'b1, 1'b0, 1'b1);  // uwe set
      add_lookup({13'h1ABC, 6'd3, 13'h000C}, 1'b1, 1'b0, 1'b1, 1'b1);  // sre set
      add_lookup({13'h1ABC, 6'd3, 13'h0010}, 1'b0, 1'b1, 1'b1, 1'b1);  // swe clear
      add_lookup({13'h1ABC, 6'd3, 13'h0014}, 1'b0, 1'b1, 1'b0, 1'b0);  // Translation off
      add_lookup({13'h0777, 6'd9, 13'h1234}, 1'b1, 1'b0, 1'b1, 1'b0);  // Off, unwritten set
      for (int k = 0; k < 6; k++) begin
         rnd = $random(seed);
         va_rnd[k] = {rnd[31:19], 6'd40 + 6'(k), rnd[12:0]};
         rnd = $random(seed);
         add_entry(6'd40 + 6'(k), match_word(va_rnd[k][31:19], 6'd40 + 6'(k), 1'b1), rnd);
      end
      for (int k = 5; k >= 0; k--) begin  // Back to back, reverse order of writes
         rnd = $random(seed);
         add_lookup(va_rnd[k], rnd[0], ~rnd[0], rnd[1], 1'b1);
      end
   endtask

   // One SPR access, stb held through the cycle that carries the ack
   task automatic run_spr(input row_t r);
      int cycles;
      int bad;
      spr_addr_i = r.addr[`DMMU_SPR_ADDR_WIDTH-1:0];
      spr_we_i   = (r.op == OP_WR);
      spr_dat_i  = r.data;
      spr_stb_i  = 1'b1;
      cycles = 0;
      bad = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (spr_ack_o !== 1'b1 && cycles < 8);
      if (spr_ack_o !== 1'b1) begin
         bad++;
         $display("row %0d: SPR access got no ack within %0d cycles", r.idx, cycles);
      end else if (cycles != 1) begin
         bad++;
         $display("row %0d: SPR ack came %0d cycles after the strobe, not one", r.idx, cycles);
      end
      if (r.op == OP_RD && spr_dat_o !== r.exp_data) begin
         bad++;
         $display("ERROR row %0d spr_dat_o got %h expected %h", r.idx, spr_dat_o, r.exp_data);
      end
      @(negedge clk);  // Strobe still high across the edge that sees the ack
      if (spr_ack_o !== 1'b0) begin
         bad++;
         $display("row %0d: SPR ack stayed high for a second cycle", r.idx);
      end
      n_tests++;
      if (bad != 0) n_errors++;
      $display("row %0d spr %s addr %h: %s", r.idx, (r.op == OP_WR) ? "write" : "read",
               spr_addr_i, (bad != 0) ? "mismatch" : "ok");
      spr_stb_i = 1'b0;
      spr_we_i  = 1'b0;
      @(negedge clk);  // Idle cycle before the next strobe
   endtask

   // Responses arrive in request order
   always @(negedge clk) begin : rsp_monitor
      row_t e;
      int   bad;
      if (!rst && rsp_valid_o === 1'b1) begin
         bad = 0;
         if (pending_q.size() == 0) begin
            n_errors++;
            $display("response valid while no lookup was outstanding");
         end else begin
            e = pending_q.pop_front();
            if (miss_o !== e.exp_miss) begin
               bad++;
               $display("ERROR row %0d miss_o got %h expected %h", e.idx, miss_o, e.exp_miss);
            end
            if (pagefault_o !== e.exp_pf) begin
               bad++;
               $display("ERROR row %0d pagefault_o got %h expected %h", e.idx, pagefault_o,
                        e.exp_pf);
            end
            if (!e.exp_miss && paddr_o !== e.exp_data) begin  // Payload only matters on hit
               bad++;
               $display("ERROR row %0d paddr_o got %h expected %h", e.idx, paddr_o, e.exp_data);
            end
            if (!e.exp_miss && ci_o !== e.exp_ci) begin
               bad++;
               $display("ERROR row %0d ci_o got %h expected %h", e.idx, ci_o, e.exp_ci);
            end
            n_tests++;
            if (bad != 0) n_errors++;
            $display("row %0d lookup va %h: %s", e.idx, e.addr, (bad != 0) ? "mismatch" : "ok");
         end
      end
   end

   initial begin : main
      row_t r;
      int   cycles;
      rst = 1'b1;
      spr_addr_i = '0;
      spr_we_i = 1'b0;
      spr_stb_i = 1'b0;
      spr_dat_i = '0;
      req_i = 1'b0;
      vaddr_i = '0;
      load_i = 1'b0;
      store_i = 1'b0;
      supervisor_i = 1'b0;
      dmmu_en_i = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      for (int i = 0; i < tbl.size(); i++) begin
         r = tbl[i];
         r.idx = i;
         if (r.op == OP_LK) begin
            req_i        = 1'b1;  // One request per cycle
            vaddr_i      = r.addr;
            load_i       = r.ld;
            store_i      = r.st;
            supervisor_i = r.sv;
            dmmu_en_i    = r.en;
            pending_q.push_back(r);
            @(negedge clk);
         end else begin
            req_i = 1'b0;  // No lookup during an SPR access
            run_spr(r);
         end
      end
      req_i = 1'b0;
      cycles = 0;
      while (pending_q.size() != 0 && cycles < 10) begin
         @(negedge clk);
         cycles++;
      end
      if (pending_q.size() != 0) begin
         n_errors++;
         $display("%0d lookup responses never arrived", pending_q.size());
      end
      $display("%0d tests run, %0d errors", n_tests, n_errors);
      if (n_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Ten cycles per table row plus reset
   initial begin : watchdog
      wait (table_ready);
      #(tbl.size() * 10 * CLK_PERIOD + RST_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the table was finished");
      $display("test failed");
      $finish;
   end

endmodule
